// ==== verilog.f ====
design/bridge_pkg.sv
design/startup_seq.sv
design/token_handler.sv
design/thread_ctl.sv
design/no_data_timer.sv
design/bridge_top.sv
bench/bridge_assert.sv
bench/bridge_tb.sv

// ==== Makefile ====
LOG = sim.log

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module bridge_tb -Mdir obj_dir -o bridge_sim
	./obj_dir/bridge_sim > $(LOG) 2>&1; cat $(LOG)
	! grep -q "CHECKS FAILED" $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

// ==== bench/bridge_tb.sv ====
`timescale 1ns/10ps

module bridge_tb import bridge_pkg::*; ();

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int NO_DATA_MAX = 5;
  localparam logic [31:0] own_idx = 32'h0000_0003;
  // cycle budget of the six tests together
  localparam int test_cycles = 250;

  logic clk, ext_rst_b, read_q, write_q, chan_op, bus_busy_in, ext_next_cpu_q;
  logic no_data_new, no_data_tick;
  logic [state_w-1:0] state;
  logic [31:0] addr_in, data_in, ext_cpu_index;
  logic rst, ext_rst_e, bus_busy_out, ext_dispatcher_q, ext_next_cpu_e, disp_online;
  logic next_state, ext_read_q, ext_write_q, no_data_exit_and_wait_begin;
  logic [msg_w-1:0] ext_cpu_msg;
  logic [31:0] base_addr, base_addr_data, addr_out, data_out;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int failed_tests = 0;
  logic [15:0] lfsr = 16'd48575;
  // base registers as the last start grant should have left them
  logic [31:0] exp_ba = '0;
  logic [31:0] exp_bad = '0;

  bridge_top #(.ADDR_W(ADDR_W), .DATA_W(DATA_W), .NO_DATA_MAX(NO_DATA_MAX)) dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // galois form, taps 16 14 13 11
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic b;
    r = '0;
    for (int i = 0; i < n; i++) begin
      b = lfsr[0];
      lfsr = lfsr >> 1;
      if (b) lfsr = lfsr ^ 16'hB400;
      r = {r[30:0], b};
    end
    return r;
  endfunction

  // expected message on a grant, base addresses, bus gating and timer flag
  function automatic void bridge_ref(input logic [state_w-1:0] st, input logic [31:0] a, d,
      input logic rq, wq, online, input int ticks, output logic [msg_w-1:0] msg,
      output logic [31:0] ba, bad, output logic erq, ewq, flag);
    logic rd_cls;
    logic wr_cls;
    rd_cls = st inside {read_mem_size_1, read_dst, read_dst_p, read_cond, read_cond_p,
      read_src1, read_src1_p, read_src0, read_src0_p, start_read_cmd, start_read_cmd_p};
    wr_cls = st inside {write_reg_ip, write_dst, write_dst_p, write_src1, write_src0,
      write_cond};
    case (st)
      wait_for_start: msg = msg_start;
      finish_begin: msg = msg_end;
      break_save_ip_and_wait, break_exit_and_wait: msg = msg_break_thread;
      default: msg = msg_none;
    endcase
    ba = a + 32'(thread_header_space);
    bad = (d != 0) ? d + 32'(thread_header_space) : ba;
    erq = rd_cls && online && rq;
    ewq = wr_cls && online && wq;
    // the tick after the count reaches the limit raises it
    flag = ticks > NO_DATA_MAX;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("mismatch %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %s done, no errors", name);
    end else begin
      failed_tests++;
      $display("test %s done, %0d errors", name, errors - err_before);
    end
  endtask

  // sel 0 watches the ack, sel 1 the online flag
  task automatic wait_sig(input int sel, input logic val, input int limit);
    int n;
    logic ok;
    n = 0;
    ok = 1'b0;
    while (!ok && n < limit) begin
      @(negedge clk);
      ok = ((sel == 0) ? ext_next_cpu_e : disp_online) == val;
      n++;
    end
    checks++;
    assert (ok) else begin
      $display("timed out waiting for %s to become %0d",
        (sel == 0) ? "ext_next_cpu_e" : "disp_online", val);
      errors++;
    end
  endtask

  // full own-index grant in a state that hands the token back
  task automatic token_grant(input logic [state_w-1:0] st, input logic [31:0] a, d);
    logic [msg_w-1:0] m;
    logic [31:0] ba, bad;
    logic erq, ewq, flg;
    bridge_ref(st, a, d, 1'b0, 1'b0, 1'b0, 0, m, ba, bad, erq, ewq, flg);
    state = st;
    addr_in = a;
    data_in = d;
    ext_cpu_index = own_idx;
    ext_next_cpu_q = 1'b1;
    repeat (2) @(negedge clk);
    check("ext_next_cpu_e", ext_next_cpu_e, 0);
    @(negedge clk);
    // ack and message two cycles after q was sampled
    check("ext_next_cpu_e", ext_next_cpu_e, 1);
    check("ext_cpu_msg", ext_cpu_msg, m);
    check("next_state", next_state, 1);
    if (st == wait_for_start) begin
      check("base_addr", base_addr, ba);
      check("base_addr_data", base_addr_data, bad);
      exp_ba = ba;
      exp_bad = bad;
    end
    if (m == msg_break_thread) begin
      check("addr_out", addr_out, exp_ba);
      check("data_out", data_out, exp_bad);
    end
    ext_next_cpu_q = 1'b0;
    @(negedge clk);
    check("ext_cpu_msg", ext_cpu_msg, msg_none);
    check("next_state", next_state, 0);
    check("addr_out", addr_out, 0);
    check("data_out", data_out, 0);
    wait_sig(0, 1'b0, 6);
    check("disp_online", disp_online, 0);
  endtask

  // gating compared every cycle, mid low phase
  initial begin
    logic [msg_w-1:0] m;
    logic [31:0] ba, bad;
    logic erq, ewq, flg;
    forever begin
      @(negedge clk);
      #1;
      bridge_ref(state, addr_in, data_in, read_q, write_q, disp_online, 0, m, ba, bad,
        erq, ewq, flg);
      check("ext_read_q", ext_read_q, erq);
      check("ext_write_q", ext_write_q, ewq);
    end
  end

  initial begin
    #(2 * test_cycles * 4);
    $display("watchdog expired after %0d ns, tests did not finish", 2 * test_cycles * 4);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    int e0;
    int rst_cnt, erst_cnt, rmsg_cnt;
    logic [31:0] r, idx;
    logic [msg_w-1:0] m;
    logic [31:0] ba, bad;
    logic erq, ewq, flg;
    ext_rst_b = 1'b1;
    state = wait_for_start;
    addr_in = '0;
    data_in = '0;
    read_q = 1'b0;
    write_q = 1'b0;
    chan_op = 1'b0;
    bus_busy_in = 1'b0;
    ext_cpu_index = own_idx;
    ext_next_cpu_q = 1'b0;
    no_data_new = 1'b0;
    no_data_tick = 1'b0;

    // startup steps edge by edge
    e0 = errors;
    repeat (4) @(negedge clk);
    check("rst", rst, 0);
    check("ext_dispatcher_q", ext_dispatcher_q, 0);
    check("ext_cpu_msg", ext_cpu_msg, msg_none);
    ext_rst_b = 1'b0;
    @(negedge clk);
    check("ext_cpu_msg", ext_cpu_msg, msg_none);
    @(negedge clk);
    check("ext_cpu_msg", ext_cpu_msg, msg_reset);
    check("rst", rst, 0);
    @(negedge clk);
    check("rst", rst, 1);
    check("ext_rst_e", ext_rst_e, 1);
    check("bus_busy_out", bus_busy_out, 1);
    check("ext_cpu_msg", ext_cpu_msg, msg_none);
    @(negedge clk);
    check("rst", rst, 0);
    check("ext_rst_e", ext_rst_e, 0);
    check("bus_busy_out", bus_busy_out, 0);
    check("ext_dispatcher_q", ext_dispatcher_q, 1);
    @(negedge clk);
    check("ext_dispatcher_q", ext_dispatcher_q, 1);
    end_test("startup", e0);

    // start grants, second one with zero data
    e0 = errors;
    token_grant(wait_for_start, rand_bits(32), rand_bits(32) | 32'h1);
    token_grant(wait_for_start, rand_bits(32), 32'h0);
    end_test("start_grant", e0);

    // foreign index, then a grant held by a busy bus
    e0 = errors;
    idx = rand_bits(32);
    if (idx == own_idx) idx = idx ^ 32'h1;
    ext_cpu_index = idx;
    ext_next_cpu_q = 1'b1;
    repeat (8) begin
      @(negedge clk);
      check("ext_next_cpu_e", ext_next_cpu_e, 0);
      check("ext_cpu_msg", ext_cpu_msg, msg_none);
    end
    ext_next_cpu_q = 1'b0;
    repeat (3) @(negedge clk);
    addr_in = rand_bits(32);
    data_in = rand_bits(32);
    bridge_ref(wait_for_start, addr_in, data_in, 1'b0, 1'b0, 1'b0, 0, m, ba, bad,
      erq, ewq, flg);
    ext_cpu_index = own_idx;
    bus_busy_in = 1'b1;
    ext_next_cpu_q = 1'b1;
    repeat (5) begin
      @(negedge clk);
      check("ext_next_cpu_e", ext_next_cpu_e, 0);
      check("disp_online", disp_online, 0);
    end
    bus_busy_in = 1'b0;
    wait_sig(0, 1'b1, 6);
    check("ext_cpu_msg", ext_cpu_msg, m);
    check("base_addr", base_addr, ba);
    check("base_addr_data", base_addr_data, bad);
    exp_ba = ba;
    exp_bad = bad;
    ext_next_cpu_q = 1'b0;
    wait_sig(0, 1'b0, 6);
    end_test("foreign_and_busy", e0);

    // random states offline, then online until a read is presented
    e0 = errors;
    repeat (8) begin
      r = rand_bits(8);
      state = r[state_w-1:0];
      // finish_end would restart the sequencer
      if (state == finish_end) state = finish_begin;
      read_q = r[6];
      write_q = r[7];
      @(negedge clk);
    end
    state = read_dst;
    read_q = 1'b0;
    write_q = 1'b0;
    ext_next_cpu_q = 1'b1;
    wait_sig(1, 1'b1, 6);
    repeat (2) @(negedge clk);
    check("ext_next_cpu_e", ext_next_cpu_e, 0);
    read_q = 1'b1;
    wait_sig(0, 1'b1, 3);
    repeat (12) begin
      r = rand_bits(8);
      state = r[state_w-1:0];
      if (state == finish_end) state = finish_begin;
      read_q = r[6];
      write_q = r[7];
      @(negedge clk);
    end
    state = wait_for_start;
    read_q = 1'b0;
    write_q = 1'b0;
    ext_next_cpu_q = 1'b0;
    wait_sig(0, 1'b0, 6);
    end_test("bus_gating", e0);

    // idle ticks up to the flag
    e0 = errors;
    no_data_tick = 1'b1;
    for (int i = 1; i <= NO_DATA_MAX + 1; i++) begin
      @(negedge clk);
      bridge_ref(state, addr_in, data_in, 1'b0, 1'b0, 1'b0, i, m, ba, bad, erq, ewq, flg);
      check("no_data_exit_and_wait_begin", no_data_exit_and_wait_begin, flg);
    end
    no_data_tick = 1'b0;
    state = read_src0;
    repeat (2) begin
      @(negedge clk);
      check("next_state", next_state, 1);
    end
    state = wait_for_start;
    no_data_new = 1'b1;
    @(negedge clk);
    no_data_new = 1'b0;
    check("no_data_exit_and_wait_begin", no_data_exit_and_wait_begin, 0);
    end_test("no_data_timer", e0);

    // break and finish grants, then the restart
    e0 = errors;
    token_grant(break_save_ip_and_wait, rand_bits(32), rand_bits(32));
    token_grant(finish_begin, rand_bits(32), rand_bits(32));
    state = finish_end;
    @(negedge clk);
    state = wait_for_start;
    rst_cnt = 0;
    erst_cnt = 0;
    rmsg_cnt = 0;
    repeat (10) begin
      @(negedge clk);
      if (rst) rst_cnt++;
      if (ext_rst_e) erst_cnt++;
      if (ext_cpu_msg == msg_reset) rmsg_cnt++;
    end
    check("rst pulse count", rst_cnt, 1);
    check("ext_rst_e pulse count", erst_cnt, 0);
    check("msg_reset count", rmsg_cnt, 0);
    check("ext_dispatcher_q", ext_dispatcher_q, 1);
    end_test("break_finish_restart", e0);

    // bound assertion failures count as errors too
    errors += dut_i.assert_i.fail_cnt;
    $display("tests %0d failed %0d checks %0d errors %0d", tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== bench/bridge_assert.sv ====
`timescale 1ns/10ps

module bridge_assert (
  input logic clk,
  input logic ext_rst_b,
  input logic ext_next_cpu_q,
  input logic ext_next_cpu_e,
  input logic read_q,
  input logic ext_read_q,
  input logic ext_dispatcher_q,
  input logic rst
);

  // assertion failures so far
  int fail_cnt = 0;

  // ack only answers a raised request
  ack_rise: assert property (@(posedge clk) disable iff (ext_rst_b)
    $rose(ext_next_cpu_e) |-> $past(ext_next_cpu_q))
    else begin
      $error("ext_next_cpu_e rose while ext_next_cpu_q was low");
      fail_cnt++;
    end

  // q registered once inside the handler, so look two edges back
  ack_fall: assert property (@(posedge clk) disable iff (ext_rst_b)
    $fell(ext_next_cpu_e) |-> !$past(ext_next_cpu_q, 2))
    else begin
      $error("ext_next_cpu_e fell while ext_next_cpu_q was still high");
      fail_cnt++;
    end

  // bus reads only for a core request while the dispatcher is held
  read_gate: assert property (@(posedge clk) disable iff (ext_rst_b)
    ext_read_q |-> read_q && ext_dispatcher_q)
    else begin
      $error("ext_read_q high without read_q or without the dispatcher held");
      fail_cnt++;
    end

  // core reset lasts one cycle
  rst_pulse: assert property (@(posedge clk) disable iff (ext_rst_b)
    rst |=> !rst)
    else begin
      $error("rst held longer than one cycle");
      fail_cnt++;
    end

endmodule

bind bridge_top bridge_assert assert_i (
  .clk(clk), .ext_rst_b(ext_rst_b), .ext_next_cpu_q(ext_next_cpu_q),
  .ext_next_cpu_e(ext_next_cpu_e), .read_q(read_q), .ext_read_q(ext_read_q),
  .ext_dispatcher_q(ext_dispatcher_q), .rst(rst)
);

// ==== design/bridge_top.sv ====
`timescale 1ns/10ps

module bridge_top import bridge_pkg::*; #(
  parameter int ADDR_W      = 32,
  parameter int DATA_W      = 32,
  parameter int NO_DATA_MAX = 200
) (
  input  logic               clk,
  input  logic               ext_rst_b,
  input  logic [state_w-1:0] state,
  input  logic [ADDR_W-1:0]  addr_in,
  input  logic [DATA_W-1:0]  data_in,
  input  logic               read_q,
  input  logic               write_q,
  input  logic               chan_op,
  input  logic               bus_busy_in,
  input  logic [DATA_W-1:0]  ext_cpu_index,
  input  logic               ext_next_cpu_q,
  input  logic               no_data_new,
  input  logic               no_data_tick,
  output logic               rst,
  output logic               ext_rst_e,
  output logic               bus_busy_out,
  output logic               ext_dispatcher_q,
  output logic               ext_next_cpu_e,
  output logic               disp_online,
  output logic               next_state,
  output logic [msg_w-1:0]   ext_cpu_msg,
  output logic [ADDR_W-1:0]  base_addr,
  output logic [ADDR_W-1:0]  base_addr_data,
  output logic [ADDR_W-1:0]  addr_out,
  output logic [DATA_W-1:0]  data_out,
  output logic               ext_read_q,
  output logic               ext_write_q,
  output logic               no_data_exit_and_wait_begin
);

  // index held since startup
  logic [DATA_W-1:0] own_index;
  // sequencer done, core may take grants
  logic run;
  // startup asks for the reset message
  logic reset_msg;
  // one cycle per own-index grant
  logic grant;
  // thread_ctl returns the token at once
  logic hand_back;

  startup_seq #(.DATA_W(DATA_W)) seq_i (
    .clk(clk), .ext_rst_b(ext_rst_b), .state(state), .ext_cpu_index(ext_cpu_index),
    .own_index(own_index), .run(run), .reset_msg(reset_msg), .rst(rst),
    .ext_rst_e(ext_rst_e), .bus_busy_out(bus_busy_out), .ext_dispatcher_q(ext_dispatcher_q)
  );

  token_handler #(.DATA_W(DATA_W)) tok_i (
    .clk(clk), .ext_rst_b(ext_rst_b), .run(run), .own_index(own_index),
    .ext_cpu_index(ext_cpu_index), .ext_next_cpu_q(ext_next_cpu_q), .bus_busy_in(bus_busy_in),
    .read_q(read_q), .write_q(write_q), .chan_op(chan_op), .hand_back(hand_back),
    .grant(grant), .disp_online(disp_online), .ext_next_cpu_e(ext_next_cpu_e)
  );

  thread_ctl #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) thr_i (
    .clk(clk), .ext_rst_b(ext_rst_b), .grant(grant), .run(run), .state(state),
    .addr_in(addr_in), .data_in(data_in), .read_q(read_q), .write_q(write_q),
    .disp_online(disp_online), .bus_busy_in(bus_busy_in), .reset_msg(reset_msg),
    .exit_wait(no_data_exit_and_wait_begin), .hand_back(hand_back), .next_state(next_state),
    .ext_cpu_msg(ext_cpu_msg), .base_addr(base_addr), .base_addr_data(base_addr_data),
    .addr_out(addr_out), .data_out(data_out), .ext_read_q(ext_read_q), .ext_write_q(ext_write_q)
  );

  // exit flag goes straight out of the top
  no_data_timer #(.NO_DATA_MAX(NO_DATA_MAX)) tmr_i (
    .clk(clk), .ext_rst_b(ext_rst_b), .run(run), .no_data_new(no_data_new),
    .no_data_tick(no_data_tick), .exit_wait(no_data_exit_and_wait_begin)
  );

endmodule

// ==== design/no_data_timer.sv ====
`timescale 1ns/10ps

module no_data_timer #(
  parameter int NO_DATA_MAX = 200
) (
  input  logic clk,
  input  logic ext_rst_b,
  input  logic run,
  input  logic no_data_new,
  input  logic no_data_tick,
  output logic exit_wait
);

  localparam int cnt_w = $clog2(NO_DATA_MAX + 1);

  // idle ticks since the last data
  logic [cnt_w-1:0] cnt;

  always_ff @(posedge clk) begin
    // held clear through startup and on new data
    if (ext_rst_b || !run || no_data_new) begin
      cnt       <= '0;
      exit_wait <= 1'b0;
    end else if (no_data_tick) begin
      if (cnt == cnt_w'(NO_DATA_MAX)) begin
        // limit reached, wrap and raise the flag
        cnt       <= '0;
        exit_wait <= 1'b1;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

// ==== design/thread_ctl.sv ====
`timescale 1ns/10ps

module thread_ctl import bridge_pkg::*; #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic               clk,
  input  logic               ext_rst_b,
  input  logic               grant,
  input  logic               run,
  input  logic [state_w-1:0] state,
  input  logic [ADDR_W-1:0]  addr_in,
  input  logic [DATA_W-1:0]  data_in,
  input  logic               read_q,
  input  logic               write_q,
  input  logic               disp_online,
  input  logic               bus_busy_in,
  input  logic               reset_msg,
  input  logic               exit_wait,
  output logic               hand_back,
  output logic               next_state,
  output logic [msg_w-1:0]   ext_cpu_msg,
  output logic [ADDR_W-1:0]  base_addr,
  output logic [ADDR_W-1:0]  base_addr_data,
  output logic [ADDR_W-1:0]  addr_out,
  output logic [DATA_W-1:0]  data_out,
  output logic               ext_read_q,
  output logic               ext_write_q
);

  localparam logic [ADDR_W-1:0] hdr_space = ADDR_W'(thread_header_space);

  logic read_cls;
  logic write_cls;
  // states that give the token back on their grant
  logic hb_state;
  // grant taken this cycle
  logic upd;

  always_comb begin
    read_cls  = 1'b0;
    write_cls = 1'b0;
    hb_state  = 1'b0;
    case (state)
      read_mem_size_1, read_dst, read_dst_p, read_cond, read_cond_p, read_src1,
      read_src1_p, read_src0, read_src0_p, start_read_cmd, start_read_cmd_p:
        read_cls = 1'b1;
      write_reg_ip, write_dst, write_dst_p, write_src1, write_src0, write_cond:
        write_cls = 1'b1;
      wait_for_start, finish_begin, break_save_ip_and_wait, break_exit_and_wait,
      aux_pre_finish_begin:
        hb_state = 1'b1;
      default: ;
    endcase
  end

  assign upd       = grant && run && !bus_busy_in;
  assign hand_back = upd && hb_state;

  // requests pass only in the matching class while online
  assign ext_read_q  = read_cls && disp_online && read_q;
  assign ext_write_q = write_cls && disp_online && write_q;

  // base addresses shown to the dispatcher with a break message only
  assign addr_out = (ext_cpu_msg == msg_break_thread) ? base_addr : '0;
  assign data_out = (ext_cpu_msg == msg_break_thread) ? DATA_W'(base_addr_data) : '0;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      ext_cpu_msg <= msg_none;
      next_state  <= 1'b0;
    end else begin
      // message is a one cycle word
      ext_cpu_msg <= msg_none;
      if (reset_msg) begin
        ext_cpu_msg <= msg_reset;
      end else if (upd) begin
        case (state)
          wait_for_start:                              ext_cpu_msg <= msg_start;
          finish_begin:                                ext_cpu_msg <= msg_end;
          break_save_ip_and_wait, break_exit_and_wait: ext_cpu_msg <= msg_break_thread;
          default: ;
        endcase
      end
      // advance on handed back grants, and keep advancing out of reads when idle
      next_state <= hand_back || (exit_wait && read_cls);
    end
  end

  // thread base addresses, loaded on a start grant
  always_ff @(posedge clk) begin
    if (upd && (state == wait_for_start)) begin
      base_addr <= addr_in + hdr_space;
      if (data_in != '0) begin
        base_addr_data <= ADDR_W'(data_in) + hdr_space;
      end else begin
        base_addr_data <= addr_in + hdr_space;
      end
    end
  end

endmodule

// ==== design/token_handler.sv ====
`timescale 1ns/10ps

module token_handler #(
  parameter int DATA_W = 32
) (
  input  logic              clk,
  input  logic              ext_rst_b,
  input  logic              run,
  input  logic [DATA_W-1:0] own_index,
  input  logic [DATA_W-1:0] ext_cpu_index,
  input  logic              ext_next_cpu_q,
  input  logic              bus_busy_in,
  input  logic              read_q,
  input  logic              write_q,
  input  logic              chan_op,
  input  logic              hand_back,
  output logic              grant,
  output logic              disp_online,
  output logic              ext_next_cpu_e
);

  // q as sampled, and the value seen at the last unfrozen edge
  logic q_r;
  logic q_seen;
  // rising q for this core
  logic hit;
  // core side work that ends the grant
  logic core_done;

  assign hit       = run && !bus_busy_in && q_r && !q_seen && (ext_cpu_index == own_index);
  assign core_done = disp_online && (read_q || write_q || chan_op);

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      q_r            <= 1'b0;
      q_seen         <= 1'b0;
      grant          <= 1'b0;
      disp_online    <= 1'b0;
      ext_next_cpu_e <= 1'b0;
    end else begin
      q_r <= ext_next_cpu_q;
      // busy bus holds the edge detector, rise stays pending
      if (!bus_busy_in) begin
        q_seen <= q_r;
      end
      grant <= hit;
      if (hit) begin
        disp_online <= 1'b1;
      end
      if (!ext_next_cpu_e) begin
        // ack either straight from the grant or once the core acts
        if (hand_back || core_done) begin
          ext_next_cpu_e <= 1'b1;
        end
      end else if (!q_r) begin
        // dispatcher released q, close the handshake
        ext_next_cpu_e <= 1'b0;
        disp_online    <= 1'b0;
      end
    end
  end

endmodule

// ==== design/startup_seq.sv ====
`timescale 1ns/10ps

module startup_seq import bridge_pkg::*; #(
  parameter int DATA_W = 32
) (
  input  logic               clk,
  input  logic               ext_rst_b,
  input  logic [state_w-1:0] state,
  input  logic [DATA_W-1:0]  ext_cpu_index,
  output logic [DATA_W-1:0]  own_index,
  output logic               run,
  output logic               reset_msg,
  output logic               rst,
  output logic               ext_rst_e,
  output logic               bus_busy_out,
  output logic               ext_dispatcher_q
);

  // steps 1 to 5, step 5 holds while running
  logic [2:0] step;
  // set once a thread has finished, so later passes are restarts
  logic restart;
  // no capture and no external reset this pass
  logic skip;

  assign skip = restart || (state == finish_end);

  // combinational so the message register loads on the capture edge
  assign reset_msg = (step == 3'd2) && !skip;

  always_ff @(posedge clk) begin
    if (ext_rst_b) begin
      step             <= 3'd1;
      restart          <= 1'b0;
      run              <= 1'b0;
      rst              <= 1'b0;
      ext_rst_e        <= 1'b0;
      bus_busy_out     <= 1'b0;
      ext_dispatcher_q <= 1'b0;
    end else begin
      case (step)
        3'd1: begin
          // drop out of the dispatcher round
          ext_dispatcher_q <= 1'b0;
          step             <= 3'd2;
        end
        3'd2: begin
          restart <= skip;
          step    <= 3'd3;
        end
        3'd3: begin
          // core reset pulse, external one only on a cold start
          rst          <= 1'b1;
          bus_busy_out <= 1'b1;
          ext_rst_e    <= !restart;
          step         <= 3'd4;
        end
        3'd4: begin
          rst              <= 1'b0;
          bus_busy_out     <= 1'b0;
          ext_rst_e        <= 1'b0;
          ext_dispatcher_q <= 1'b1;
          step             <= 3'd5;
        end
        3'd5: begin
          if (!run) begin
            run <= 1'b1;
          end else if (state == finish_end) begin
            // thread over, run the sequence again
            run     <= 1'b0;
            restart <= 1'b1;
            step    <= 3'd1;
          end
        end
        default: step <= 3'd1;
      endcase
    end
  end

  // index latched once, held over restarts
  always_ff @(posedge clk) begin
    if (reset_msg) begin
      own_index <= ext_cpu_index;
    end
  end

endmodule

// ==== design/bridge_pkg.sv ====
package bridge_pkg;

  // core state code and dispatcher message widths
  localparam int state_w = 6;
  localparam int msg_w   = 4;

  // idle, waiting for a thread start
  localparam logic [state_w-1:0] wait_for_start   = 6'd0;

  // read class, bus reads pass while online
  localparam logic [state_w-1:0] read_mem_size_1  = 6'd1;
  localparam logic [state_w-1:0] read_dst         = 6'd2;
  localparam logic [state_w-1:0] read_dst_p       = 6'd3;
  localparam logic [state_w-1:0] read_cond        = 6'd4;
  localparam logic [state_w-1:0] read_cond_p      = 6'd5;
  localparam logic [state_w-1:0] read_src1        = 6'd6;
  localparam logic [state_w-1:0] read_src1_p      = 6'd7;
  localparam logic [state_w-1:0] read_src0        = 6'd8;
  localparam logic [state_w-1:0] read_src0_p      = 6'd9;
  localparam logic [state_w-1:0] start_read_cmd   = 6'd10;
  localparam logic [state_w-1:0] start_read_cmd_p = 6'd11;

  // write class
  localparam logic [state_w-1:0] write_reg_ip     = 6'd12;
  localparam logic [state_w-1:0] write_dst        = 6'd13;
  localparam logic [state_w-1:0] write_dst_p      = 6'd14;
  localparam logic [state_w-1:0] write_src1       = 6'd15;
  localparam logic [state_w-1:0] write_src0       = 6'd16;
  localparam logic [state_w-1:0] write_cond       = 6'd17;

  // thread end and break handling
  localparam logic [state_w-1:0] finish_begin           = 6'd18;
  localparam logic [state_w-1:0] finish_end             = 6'd19;
  localparam logic [state_w-1:0] break_save_ip_and_wait = 6'd20;
  localparam logic [state_w-1:0] break_exit_and_wait    = 6'd21;
  localparam logic [state_w-1:0] aux_pre_finish_begin   = 6'd22;
  localparam logic [state_w-1:0] alu_begin              = 6'd23;

  // words sent to the dispatcher, zero means nothing sent
  localparam logic [msg_w-1:0] msg_none         = 4'd0;
  localparam logic [msg_w-1:0] msg_reset        = 4'd1;
  localparam logic [msg_w-1:0] msg_start        = 4'd2;
  localparam logic [msg_w-1:0] msg_end          = 4'd3;
  localparam logic [msg_w-1:0] msg_break_thread = 4'd4;

  // offset past the thread header, resized to the address width where used
  localparam int unsigned thread_header_space = 16;

endpackage
